// File: spriteGeomPkg.sv
package spriteGeomPkg;

    // Cell geometry
    localparam int CELL_W        = 16;
    localparam int X_BITS        = $clog2(CELL_W);
    localparam int PLAYER_H      = 32;
    localparam int PLAYER_Y_BITS = $clog2(PLAYER_H);
    localparam int TILE_H        = 16;
    localparam int TILE_Y_BITS   = $clog2(TILE_H);

    // Pixel and colour formats
    localparam int PIX_BITS = 4;
    localparam int RGB_BITS = 24;

    typedef logic [PIX_BITS-1:0] pixIdxT;   // Colour index where 0 is transparent
    typedef logic [RGB_BITS-1:0] rgbT;

    localparam int TILE_KIND_BITS = 2;
    localparam int BANK_BITS      = 2;

    // Player ROM address is {crouch, row, column}
    localparam int PLAYER_ADDR_BITS = 1 + PLAYER_Y_BITS + X_BITS;
    // Tile ROM address is {kind, row, column}
    localparam int TILE_ADDR_BITS   = TILE_KIND_BITS + TILE_Y_BITS + X_BITS;
    // Palette address is {bank, index}
    localparam int PAL_ADDR_BITS    = BANK_BITS + PIX_BITS;

    localparam int PLAYER_DEPTH = 1 << PLAYER_ADDR_BITS;
    localparam int TILE_DEPTH   = 1 << TILE_ADDR_BITS;
    localparam int PAL_DEPTH    = 1 << PAL_ADDR_BITS;

    typedef enum logic [TILE_KIND_BITS-1:0] {
        TILE_GROUND   = 2'd0,   // Grass over brick
        TILE_BRICK    = 2'd1,
        TILE_QUESTION = 2'd2
    } tileKindT;

    typedef enum logic {
        LAYER_PLAYER = 1'b0,
        LAYER_TILE   = 1'b1
    } layerT;

    typedef enum logic [BANK_BITS-1:0] {
        BANK_PLAYER_RED   = 2'd0,
        BANK_PLAYER_GREEN = 2'd1,
        BANK_TILE         = 2'd2
    } palBankT;

    // Selects which image a ROM instance is loaded with
    typedef enum logic [1:0] {
        ROM_PLAYER  = 2'd0,
        ROM_TILE    = 2'd1,
        ROM_PALETTE = 2'd2
    } romContentT;

endpackage

// File: spriteArtPkg.sv
package spriteArtPkg;
    import spriteGeomPkg::*;

    localparam pixIdxT IDX_CLEAR = 4'd0;

    // Player indices
    localparam pixIdxT PIDX_HAT      = 4'd1;   // Hat and shirt
    localparam pixIdxT PIDX_SKIN     = 4'd2;
    localparam pixIdxT PIDX_HAIR     = 4'd3;
    localparam pixIdxT PIDX_OVERALLS = 4'd4;
    localparam pixIdxT PIDX_SHOES    = 4'd5;
    localparam pixIdxT PIDX_BUTTONS  = 4'd6;

    // Tile indices
    localparam pixIdxT TIDX_BRICK  = 4'd1;
    localparam pixIdxT TIDX_GROUT  = 4'd2;
    localparam pixIdxT TIDX_GRASS  = 4'd3;
    localparam pixIdxT TIDX_MARK   = 4'd4;
    localparam pixIdxT TIDX_SHADOW = 4'd5;

    // Red and green player banks differ only in the hat
    localparam rgbT COL_CLEAR     = 24'h000000;
    localparam rgbT COL_RED_HAT   = 24'hE82828;
    localparam rgbT COL_GREEN_HAT = 24'h28E828;
    localparam rgbT COL_SKIN      = 24'hFFC888;
    localparam rgbT COL_HAIR      = 24'h683808;
    localparam rgbT COL_OVERALLS  = 24'h2828E8;
    localparam rgbT COL_SHOES     = 24'h884808;
    localparam rgbT COL_BUTTONS   = 24'hFFD700;

    // Tile bank
    localparam rgbT COL_BRICK  = 24'hC84810;
    localparam rgbT COL_GROUT  = 24'h803000;
    localparam rgbT COL_GRASS  = 24'h00B800;
    localparam rgbT COL_MARK   = 24'hFFFFFF;
    localparam rgbT COL_SHADOW = 24'h503010;

    typedef pixIdxT [PLAYER_DEPTH-1:0] playerImgT;
    typedef pixIdxT [TILE_DEPTH-1:0]   tileImgT;
    typedef rgbT    [PAL_DEPTH-1:0]    palImgT;

    function automatic bit inRange(input int v, input int lo, input int hi);
        return (v >= lo) && (v <= hi);
    endfunction

    function automatic pixIdxT standPix(input int y, input int x);
        pixIdxT p;
        p = IDX_CLEAR;
        case (y)
            0: if (inRange(x, 5, 10)) p = PIDX_HAT;
            1, 4: if (inRange(x, 4, 11)) p = PIDX_HAT;   // Crown and brim
            2, 3: if (inRange(x, 3, 12)) p = PIDX_HAT;
            5: begin
                if (inRange(x, 3, 5) || inRange(x, 11, 12)) p = PIDX_HAIR;
                else if (inRange(x, 6, 10)) p = PIDX_SKIN;
            end
            6: begin
                if (inRange(x, 2, 4) || x == 12) p = PIDX_HAIR;
                else if (inRange(x, 5, 11)) p = PIDX_SKIN;
            end
            7, 8: if (inRange(x, 4, 11)) p = PIDX_SKIN;
            9: if (inRange(x, 5, 10)) p = PIDX_SKIN;      // Neck
            10: if (inRange(x, 2, 13)) p = PIDX_HAT;
            11: begin
                if (inRange(x, 1, 3) || inRange(x, 12, 14)) p = PIDX_SKIN;   // Arms
                else if (inRange(x, 4, 11)) p = PIDX_HAT;
            end
            12: if (inRange(x, 4, 11)) p = PIDX_HAT;
            13, 14, 16: if (inRange(x, 3, 12)) p = PIDX_OVERALLS;
            15: begin
                if (x == 6 || x == 9) p = PIDX_BUTTONS;
                else if (inRange(x, 4, 11)) p = PIDX_OVERALLS;
            end
            17, 18, 19, 20: if (inRange(x, 2, 6) || inRange(x, 9, 13)) p = PIDX_OVERALLS;
            21, 22, 23: if (inRange(x, 1, 6) || inRange(x, 9, 14)) p = PIDX_SHOES;
            default: p = IDX_CLEAR;
        endcase
        return p;
    endfunction

    function automatic pixIdxT crouchPix(input int y, input int x);
        pixIdxT p;
        p = IDX_CLEAR;
        case (y)
            0: if (inRange(x, 5, 10)) p = PIDX_HAT;
            1: if (inRange(x, 4, 11)) p = PIDX_HAT;
            2: if (inRange(x, 3, 12)) p = PIDX_HAT;
            3: begin
                if (inRange(x, 3, 4) || inRange(x, 11, 12)) p = PIDX_HAIR;
                else if (inRange(x, 5, 10)) p = PIDX_SKIN;
            end
            4: if (inRange(x, 4, 11)) p = PIDX_SKIN;
            5, 6, 7, 8, 9: if (inRange(x, 3, 12)) p = PIDX_OVERALLS;
            10, 11, 12, 13: if (inRange(x, 2, 5) || inRange(x, 10, 13)) p = PIDX_SHOES;
            default: p = IDX_CLEAR;
        endcase
        return p;
    endfunction

    function automatic pixIdxT tilePix(input logic [TILE_KIND_BITS-1:0] kind,
                                       input int y, input int x);
        pixIdxT p;
        bit mark;
        p = TIDX_BRICK;
        case (kind)
            TILE_GROUND: begin
                if (y <= 1) p = TIDX_GRASS;
                else if (y == 2 || y == 6 || y == 10 || y == 14) p = TIDX_GROUT;
                else if ((inRange(y, 3, 5) || inRange(y, 11, 13)) && (x == 0 || x == 8))
                    p = TIDX_GROUT;
                else if (inRange(y, 7, 9) && (x == 4 || x == 12)) p = TIDX_GROUT;
            end
            TILE_BRICK: begin
                if (y == 0 || y == 8) p = TIDX_GROUT;
                else if (y < 8 && (x == 0 || x == 8)) p = TIDX_GROUT;   // Staggered joints
                else if (y > 8 && (x == 4 || x == 12)) p = TIDX_GROUT;
            end
            TILE_QUESTION: begin
                mark = (inRange(y, 4, 5) && inRange(x, 6, 9)) ||
                       (y == 6 && inRange(x, 8, 9)) ||
                       (inRange(y, 7, 8) && inRange(x, 7, 8)) ||
                       (inRange(y, 10, 11) && inRange(x, 7, 8));   // Dot
                if (mark) p = TIDX_MARK;
                else if (x == 0 || x == 15 || y == 0 || y == 15) p = TIDX_GROUT;
                else if (x == 1 || y == 1) p = TIDX_GRASS;   // Top-left highlight
                else if (x == 14 || y == 14) p = TIDX_SHADOW;
            end
            default: p = IDX_CLEAR;
        endcase
        return p;
    endfunction

    function automatic playerImgT paintPlayer();
        playerImgT img;
        img = '0;
        for (int c = 0; c < 2; c++) begin
            for (int y = 0; y < PLAYER_H; y++) begin
                for (int x = 0; x < CELL_W; x++) begin
                    img[{c[0], y[PLAYER_Y_BITS-1:0], x[X_BITS-1:0]}] =
                        (c == 0) ? standPix(y, x) : crouchPix(y, x);
                end
            end
        end
        return img;
    endfunction

    function automatic tileImgT paintTiles();
        tileImgT img;
        img = '0;
        for (int k = 0; k < 4; k++) begin
            for (int y = 0; y < TILE_H; y++) begin
                for (int x = 0; x < CELL_W; x++) begin
                    img[{k[1:0], y[TILE_Y_BITS-1:0], x[X_BITS-1:0]}] = tilePix(k[1:0], y, x);
                end
            end
        end
        return img;
    endfunction

    function automatic palImgT paintPalette();
        palImgT  img;
        palBankT bank;
        img = '0;
        for (int b = 0; b < 2; b++) begin
            bank = (b == 0) ? BANK_PLAYER_RED : BANK_PLAYER_GREEN;
            img[{bank, IDX_CLEAR}]     = COL_CLEAR;
            img[{bank, PIDX_HAT}]      = (b == 0) ? COL_RED_HAT : COL_GREEN_HAT;
            img[{bank, PIDX_SKIN}]     = COL_SKIN;
            img[{bank, PIDX_HAIR}]     = COL_HAIR;
            img[{bank, PIDX_OVERALLS}] = COL_OVERALLS;
            img[{bank, PIDX_SHOES}]    = COL_SHOES;
            img[{bank, PIDX_BUTTONS}]  = COL_BUTTONS;
        end
        img[{BANK_TILE, IDX_CLEAR}]   = COL_CLEAR;
        img[{BANK_TILE, TIDX_BRICK}]  = COL_BRICK;
        img[{BANK_TILE, TIDX_GROUT}]  = COL_GROUT;
        img[{BANK_TILE, TIDX_GRASS}]  = COL_GRASS;
        img[{BANK_TILE, TIDX_MARK}]   = COL_MARK;
        img[{BANK_TILE, TIDX_SHADOW}] = COL_SHADOW;
        return img;
    endfunction

endpackage

// File: syncRom.sv
`timescale 1ns/1ps

module syncRom
    import spriteGeomPkg::*;
    import spriteArtPkg::*;
#(
    parameter type        dataT   = pixIdxT,
    parameter int         DEPTH   = PLAYER_DEPTH,
    parameter romContentT CONTENT = ROM_PLAYER
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    output dataT                     data
);

    dataT mem [DEPTH];

    // Image is painted once at load time
    if (CONTENT == ROM_PLAYER) begin : genPlayer
        initial begin
            playerImgT img;
            img = paintPlayer();
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] = img[i];
            end
        end
    end else if (CONTENT == ROM_TILE) begin : genTile
        initial begin
            tileImgT img;
            img = paintTiles();
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] = img[i];
            end
        end
    end else begin : genPalette
        initial begin
            palImgT img;
            img = paintPalette();
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] = img[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        data <= mem[addr];   // One cycle read
    end

endmodule

// File: pixelAddrGen.sv
`timescale 1ns/1ps

module pixelAddrGen
    import spriteGeomPkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pixelReq,
    input  layerT                       layer,
    input  tileKindT                    tileKind,
    input  logic                        crouch,
    input  logic                        flip,
    input  logic                        altPalette,
    input  logic [X_BITS-1:0]           pixX,
    input  logic [PLAYER_Y_BITS-1:0]    pixY,
    output logic [PLAYER_ADDR_BITS-1:0] playerAddr,
    output logic [TILE_ADDR_BITS-1:0]   tileAddr,
    output layerT                       reqLayer,
    output logic                        reqAlt,
    output logic                        reqValid
);

    localparam logic [X_BITS-1:0] LAST_COL = X_BITS'(CELL_W - 1);

    logic [X_BITS-1:0] col;

    // Horizontal mirror for a player facing the other way
    assign col = flip ? LAST_COL - pixX : pixX;

    always_ff @(posedge clk) begin
        if (rst) begin
            reqValid <= 1'b0;
        end else begin
            reqValid <= pixelReq;
        end
    end

    // Address and side info only move on a request
    always_ff @(posedge clk) begin
        if (pixelReq) begin
            playerAddr <= {crouch, pixY, col};
            // Tiles are 16 rows high so the top row bit drops out
            tileAddr   <= {tileKind, pixY[TILE_Y_BITS-1:0], col};
            reqLayer   <= layer;
            reqAlt     <= altPalette;
        end
    end

endmodule

// File: paletteStage.sv
`timescale 1ns/1ps

module paletteStage
    import spriteGeomPkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  layerT                    reqLayer,
    input  logic                     reqAlt,
    input  logic                     reqValid,
    input  pixIdxT                   playerIdx,
    input  pixIdxT                   tileIdx,
    output logic [PAL_ADDR_BITS-1:0] palAddr,
    output logic                     opaque,
    output logic                     pixelValid
);

    layerT   layerQ;
    logic    altQ;
    logic    validQ;
    pixIdxT  idx;
    palBankT bank;

    // Side info waits one cycle for the sprite ROM read
    always_ff @(posedge clk) begin
        layerQ <= reqLayer;
        altQ   <= reqAlt;
    end

    always_comb begin
        idx = (layerQ == LAYER_TILE) ? tileIdx : playerIdx;
        if (layerQ == LAYER_TILE) begin
            bank = BANK_TILE;
        end else if (altQ) begin
            bank = BANK_PLAYER_GREEN;   // Second player
        end else begin
            bank = BANK_PLAYER_RED;
        end
    end

    assign palAddr = {bank, idx};

    // Flags line up with the palette ROM output
    always_ff @(posedge clk) begin
        if (rst) begin
            validQ     <= 1'b0;
            pixelValid <= 1'b0;
            opaque     <= 1'b0;
        end else begin
            validQ     <= reqValid;
            pixelValid <= validQ;
            opaque     <= validQ && (idx != '0);   // Index 0 is see-through
        end
    end

endmodule

// File: spritePixelPipe.sv
`timescale 1ns/1ps

module spritePixelPipe
    import spriteGeomPkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pixelReq,
    input  layerT                    layer,
    input  tileKindT                 tileKind,
    input  logic                     crouch,
    input  logic                     flip,
    input  logic                     altPalette,
    input  logic [X_BITS-1:0]        pixX,
    input  logic [PLAYER_Y_BITS-1:0] pixY,
    output rgbT                      rgb,
    output logic                     opaque,
    output logic                     pixelValid
);

    logic [PLAYER_ADDR_BITS-1:0] playerAddr;
    logic [TILE_ADDR_BITS-1:0]   tileAddr;
    logic [PAL_ADDR_BITS-1:0]    palAddr;
    layerT                       reqLayer;
    logic                        reqAlt;
    logic                        reqValid;
    pixIdxT                      playerIdx;
    pixIdxT                      tileIdx;

    pixelAddrGen addrGen0 (
        .clk       (clk),
        .rst       (rst),
        .pixelReq  (pixelReq),
        .layer     (layer),
        .tileKind  (tileKind),
        .crouch    (crouch),
        .flip      (flip),
        .altPalette(altPalette),
        .pixX      (pixX),
        .pixY      (pixY),
        .playerAddr(playerAddr),
        .tileAddr  (tileAddr),
        .reqLayer  (reqLayer),
        .reqAlt    (reqAlt),
        .reqValid  (reqValid)
    );

    // Both sprite ROMs read every cycle and the palette stage picks one
    syncRom #(.dataT(pixIdxT), .DEPTH(PLAYER_DEPTH), .CONTENT(ROM_PLAYER)) playerRom (
        .clk (clk),
        .addr(playerAddr),
        .data(playerIdx)
    );

    syncRom #(.dataT(pixIdxT), .DEPTH(TILE_DEPTH), .CONTENT(ROM_TILE)) tileRom (
        .clk (clk),
        .addr(tileAddr),
        .data(tileIdx)
    );

    paletteStage palStage0 (
        .clk       (clk),
        .rst       (rst),
        .reqLayer  (reqLayer),
        .reqAlt    (reqAlt),
        .reqValid  (reqValid),
        .playerIdx (playerIdx),
        .tileIdx   (tileIdx),
        .palAddr   (palAddr),
        .opaque    (opaque),
        .pixelValid(pixelValid)
    );

    syncRom #(.dataT(rgbT), .DEPTH(PAL_DEPTH), .CONTENT(ROM_PALETTE)) paletteRom (
        .clk (clk),
        .addr(palAddr),
        .data(rgb)
    );

endmodule

// File: spritePixelPipe_sva.sv
`timescale 1ns/1ps

module spritePixelPipe_sva
    import spriteGeomPkg::*;
(
    input logic clk,
    input logic rst,
    input logic pixelReq,
    input logic pixelValid,
    input logic opaque,
    input rgbT  rgb
);

    // Valid flags clear on any reset cycle
    validLowAfterReset: assert property (@(posedge clk) rst |=> !pixelValid)
        else $error("pixelValid high in the cycle after reset");

    // Exactly one pixelValid per request three cycles later
    fixedLatency: assert property (@(posedge clk) disable iff (rst)
        pixelValid == $past(pixelReq, 3))
        else $error("pixelValid does not follow pixelReq by three cycles");

    opaqueNotBlack: assert property (@(posedge clk) disable iff (rst)
        opaque |-> rgb != '0)
        else $error("opaque set on a zero colour");

endmodule

bind spritePixelPipe spritePixelPipe_sva sva0 (
    .clk       (clk),
    .rst       (rst),
    .pixelReq  (pixelReq),
    .pixelValid(pixelValid),
    .opaque    (opaque),
    .rgb       (rgb)
);

// File: tb_spritePixelPipe.sv
`timescale 1ns/1ps

module tb_spritePixelPipe
    import spriteGeomPkg::*;
    import spriteArtPkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int LATENCY      = 3;
    localparam int RANDOM_REQS  = 1500;

    // One clock slot of stimulus where req low is an idle cycle
    typedef struct packed {
        logic       req;
        logic       tile;
        logic [1:0] kind;
        logic       crouch;
        logic       flip;
        logic       alt;
        logic [3:0] x;
        logic [4:0] y;
    } slotT;

    typedef struct packed {
        rgbT  rgb;
        logic opaque;
        int   issue;   // Cycle the request was driven
    } expectT;

    logic                     clk;
    logic                     rst;
    logic                     pixelReq;
    layerT                    layer;
    tileKindT                 tileKind;
    logic                     crouch;
    logic                     flip;
    logic                     altPalette;
    logic [X_BITS-1:0]        pixX;
    logic [PLAYER_Y_BITS-1:0] pixY;
    rgbT                      rgb;
    logic                     opaque;
    logic                     pixelValid;

    slotT        stim[$];
    expectT      pending[$];
    logic [31:0] lcgState;
    int          cycle;
    int          slotIdx;
    int          cycleLimit;
    int          drainCycles;
    int          checks;
    int          valueErrors;
    int          protocolErrors;

    spritePixelPipe dut0 (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic bit between(input int v, input int lo, input int hi);
        return v >= lo && v <= hi;
    endfunction

    // Player art with the hat colour taken from the palette choice
    function automatic rgbT playerColour(input bit crouched, input int y, input int x,
                                         input rgbT hat);
        if (crouched) begin
            if (y == 0) return between(x, 5, 10) ? hat : COL_CLEAR;
            if (y == 1) return between(x, 4, 11) ? hat : COL_CLEAR;
            if (y == 2) return between(x, 3, 12) ? hat : COL_CLEAR;
            if (y == 3 && (between(x, 3, 4) || between(x, 11, 12))) return COL_HAIR;
            if (y == 3) return between(x, 5, 10) ? COL_SKIN : COL_CLEAR;
            if (y == 4) return between(x, 4, 11) ? COL_SKIN : COL_CLEAR;
            if (y <= 9) return between(x, 3, 12) ? COL_OVERALLS : COL_CLEAR;
            if (y <= 13 && (between(x, 2, 5) || between(x, 10, 13))) return COL_SHOES;
            return COL_CLEAR;
        end
        if (y == 0) return between(x, 5, 10) ? hat : COL_CLEAR;
        if (y == 1 || y == 4) return between(x, 4, 11) ? hat : COL_CLEAR;
        if (y <= 3) return between(x, 3, 12) ? hat : COL_CLEAR;
        if (y == 5 && (between(x, 3, 5) || between(x, 11, 12))) return COL_HAIR;
        if (y == 5) return between(x, 6, 10) ? COL_SKIN : COL_CLEAR;
        if (y == 6 && (between(x, 2, 4) || x == 12)) return COL_HAIR;
        if (y == 6) return between(x, 5, 11) ? COL_SKIN : COL_CLEAR;
        if (y <= 8) return between(x, 4, 11) ? COL_SKIN : COL_CLEAR;
        if (y == 9) return between(x, 5, 10) ? COL_SKIN : COL_CLEAR;
        if (y == 10) return between(x, 2, 13) ? hat : COL_CLEAR;
        if (y == 11 && (between(x, 1, 3) || between(x, 12, 14))) return COL_SKIN;   // Arms
        if (y <= 12) return between(x, 4, 11) ? hat : COL_CLEAR;
        if (y == 15 && (x == 6 || x == 9)) return COL_BUTTONS;
        if (y == 15) begin
            return (between(x, 4, 5) || between(x, 7, 8) || between(x, 10, 11)) ?
                   COL_OVERALLS : COL_CLEAR;
        end
        if (y <= 16) return between(x, 3, 12) ? COL_OVERALLS : COL_CLEAR;
        if (y <= 20) return (between(x, 2, 6) || between(x, 9, 13)) ? COL_OVERALLS : COL_CLEAR;
        if (y <= 23) return (between(x, 1, 6) || between(x, 9, 14)) ? COL_SHOES : COL_CLEAR;
        return COL_CLEAR;
    endfunction

    function automatic rgbT tileColour(input logic [1:0] kind, input int y, input int x);
        bit mark;
        mark = (between(y, 4, 5) && between(x, 6, 9)) || (y == 6 && between(x, 8, 9)) ||
               ((between(y, 7, 8) || between(y, 10, 11)) && between(x, 7, 8));
        if (kind == TILE_GROUND) begin
            if (y <= 1) return COL_GRASS;
            if (y % 4 == 2) return COL_GROUT;   // Mortar every fourth row
            if ((between(y, 3, 5) || between(y, 11, 13)) && x % 8 == 0) return COL_GROUT;
            if (between(y, 7, 9) && x % 8 == 4) return COL_GROUT;
            return COL_BRICK;
        end
        if (kind == TILE_BRICK) begin
            if (y % 8 == 0) return COL_GROUT;
            if (y < 8 ? x % 8 == 0 : x % 8 == 4) return COL_GROUT;
            return COL_BRICK;
        end
        if (mark) return COL_MARK;
        if (x == 0 || x == 15 || y == 0 || y == 15) return COL_GROUT;
        if (x == 1 || y == 1) return COL_GRASS;
        if (x == 14 || y == 14) return COL_SHADOW;
        return COL_BRICK;
    endfunction

    function automatic rgbT expectPixel(input slotT s);
        int col;
        col = s.flip ? CELL_W - 1 - int'(s.x) : int'(s.x);   // Mirrored column
        if (s.tile) return tileColour(s.kind, int'(s.y[3:0]), col);
        return playerColour(s.crouch, int'(s.y), col, s.alt ? COL_GREEN_HAT : COL_RED_HAT);
    endfunction

    function automatic slotT randomSlot();
        logic [31:0] r;
        slotT        s;
        r      = nextRand();
        s      = {1'b1, r[31:17]};
        s.kind = 2'(r[16:8] % 3);   // Ground, brick or question only
        return s;
    endfunction

    task automatic queueRequest(input slotT s);
        if (nextRand() < 32'h5555_5555) begin
            stim.push_back('0);
        end
        stim.push_back(s);
    endtask

    task automatic buildStimulus();
        slotT s;
        // Every player pixel over pose, facing and palette
        for (int i = 0; i < 4096; i++) begin
            s      = randomSlot();
            s.tile = 1'b0;
            {s.alt, s.flip, s.crouch, s.y, s.x} = i[11:0];
            queueRequest(s);
        end
        // Every pixel of the three tiles with y bit 4 left random
        for (int i = 0; i < 768; i++) begin
            s      = randomSlot();
            s.tile = 1'b1;
            {s.kind, s.y[3:0], s.x} = i[9:0];
            queueRequest(s);
        end
        for (int i = 0; i < RANDOM_REQS; i++) begin
            queueRequest(randomSlot());
        end
    endtask

    task automatic finishRun(input bit timedOut);
        if (timedOut) begin
            protocolErrors++;
            $display("Timeout at cycle %0d with %0d pixels still outstanding",
                     cycle, pending.size());
        end
        $display("Errors: %0d value, %0d protocol, %0d pixels checked",
                 valueErrors, protocolErrors, checks);
        if (valueErrors + protocolErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        pixelReq   = 1'b0;
        layer      = LAYER_PLAYER;
        tileKind   = TILE_GROUND;
        crouch     = 1'b0;
        flip       = 1'b0;
        altPalette = 1'b0;
        pixX       = '0;
        pixY       = '0;
        lcgState   = 32'h7a7d_5518;
        buildStimulus();
        cycleLimit = RESET_CYCLES + stim.size() + 50;
    end

    // One stimulus slot per clock once reset is released
    always @(posedge clk) begin
        slotT   s;
        expectT e;
        cycle = cycle + 1;
        if (cycle == RESET_CYCLES) begin
            rst <= 1'b0;
        end
        s = '0;
        if (!rst && slotIdx < stim.size()) begin
            s       = stim[slotIdx];
            slotIdx = slotIdx + 1;
        end
        pixelReq   <= s.req;
        layer      <= s.tile ? LAYER_TILE : LAYER_PLAYER;
        tileKind   <= tileKindT'(s.kind);
        crouch     <= s.crouch;
        flip       <= s.flip;
        altPalette <= s.alt;
        pixX       <= s.x;
        pixY       <= s.y;
        if (s.req) begin
            e.rgb    = expectPixel(s);
            e.opaque = e.rgb != COL_CLEAR;   // Only the clear index is black
            e.issue  = cycle;
            pending.push_back(e);
        end
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        expectT e;
        bit     late;
        if (cycle > RESET_CYCLES) begin
            if (pixelValid) begin
                assert (pending.size() > 0)
                else begin
                    protocolErrors++;
                    $display("Error at %0t: pixelValid high with no request in flight", $time);
                end
                if (pending.size() > 0) begin
                    e = pending.pop_front();
                    checks++;
                    assert (cycle - e.issue == LATENCY)
                    else begin
                        protocolErrors++;
                        $display("Error at %0t: pixel came out %0d cycles after its request",
                                 $time, cycle - e.issue);
                    end
                    assert (rgb == e.rgb)
                    else begin
                        valueErrors++;
                        $display("[FAIL] %0t rgb: got %06h, expected %06h", $time, rgb, e.rgb);
                    end
                    assert (opaque == e.opaque)
                    else begin
                        valueErrors++;
                        $display("[FAIL] %0t opaque: got %0b, expected %0b",
                                 $time, opaque, e.opaque);
                    end
                end
            end
            late = 1'b0;
            if (pending.size() > 0) begin
                late = cycle - pending[0].issue > LATENCY;
            end
            assert (!late)
            else begin
                protocolErrors++;
                $display("Error at %0t: request from cycle %0d never gave pixelValid",
                         $time, pending[0].issue);
            end
            if (late) begin
                void'(pending.pop_front());
            end
            if (cycle >= cycleLimit) begin
                finishRun(1'b1);
            end else if (slotIdx == stim.size() && pending.size() == 0) begin
                drainCycles++;
                if (drainCycles > LATENCY + 1) begin
                    finishRun(1'b0);
                end
            end
        end
    end

endmodule

// File: build.f
spriteGeomPkg.sv
spriteArtPkg.sv
syncRom.sv
pixelAddrGen.sv
paletteStage.sv
spritePixelPipe.sv
spritePixelPipe_sva.sv
tb_spritePixelPipe.sv

// File: Makefile
TOP = tb_spritePixelPipe

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
